//--- design/dispPkg.sv
// ***********************************************************
// dispPkg: shared types and constants for the seven-segment
// display controller, plus the hex glyph decode
// ***********************************************************
`default_nettype none

package dispPkg;

    parameter int VALUE_W = 16;     // displayed value width
    parameter int DIGITS  = 4;      // number of multiplexed digits
    parameter int ADDR_W  = 4;      // APB address width
    parameter int DATA_W  = 32;     // APB data width

    // APB register map, byte offsets
    typedef enum logic [ADDR_W-1:0] {
        VALUE_ADDR    = 4'h0,   // value to show
        CTRL_ADDR     = 4'h4,   // bit 0 enable, bit 1 neg
        INTERVAL_ADDR = 4'h8,   // scan interval in clocks minus one
        STATUS_ADDR   = 4'hC    // read only, bits 1:0 digit select
    } regAddrE;

    // digit position, DIG0 is the least significant nibble
    typedef enum logic [1:0] {
        DIG0 = 2'd0,
        DIG1 = 2'd1,
        DIG2 = 2'd2,
        DIG3 = 2'd3
    } digitSelE;

    // nibble to active-low segments, bit 6 is a down to bit 0 as g
    function automatic logic [6:0] hexToSeg(input logic [3:0] nib);
        logic [6:0] seg;
        case (nib)
            4'h0:    seg = 7'b0000001;
            4'h1:    seg = 7'b1001111;
            4'h2:    seg = 7'b0010010;
            4'h3:    seg = 7'b0000110;
            4'h4:    seg = 7'b1001100;
            4'h5:    seg = 7'b0100100;
            4'h6:    seg = 7'b0100000;
            4'h7:    seg = 7'b0001111;
            4'h8:    seg = 7'b0000000;
            4'h9:    seg = 7'b0000100;
            4'hA:    seg = 7'b0001000;
            4'hB:    seg = 7'b1100000;  // lower-case b
            4'hC:    seg = 7'b0110001;
            4'hD:    seg = 7'b1000010;  // lower-case d
            4'hE:    seg = 7'b0110000;
            4'hF:    seg = 7'b0111000;
            default: seg = 7'b1111111;
        endcase
        return seg;
    endfunction

endpackage

`default_nettype wire

//--- design/dispCfgIf.sv
// ***********************************************************
// dispCfgIf: register fields from the APB block to the scan
// engine, digit select back for status readout
// ***********************************************************
`default_nettype none

interface dispCfgIf #(
    parameter int CNT_W = 16
);

    logic [dispPkg::VALUE_W-1:0] value;     // hex value on the digits
    logic                        neg;       // lights DIG0 decimal point
    logic                        enable;    // low blanks all digits
    logic [CNT_W-1:0]            interval;  // tick spacing minus one
    dispPkg::digitSelE           sel;       // digit being shown

    // register side
    modport regs (
        output value, neg, enable, interval,
        input  sel
    );

    // scan side
    modport scan (
        input  value, neg, enable, interval,
        output sel
    );

endinterface

`default_nettype wire

//--- design/dispRegs.sv
// ***********************************************************
// dispRegs: APB slave with value, control, interval and a
// read-only status register, no wait states
// ***********************************************************
`default_nettype none

module dispRegs #(
    parameter int CNT_W          = 16,
    parameter int RESET_INTERVAL = 49999
) (
    input  wire logic                        CLK,
    input  wire logic                        rstN,
    input  wire logic [dispPkg::ADDR_W-1:0]  paddr,
    input  wire logic                        psel,
    input  wire logic                        penable,
    input  wire logic                        pwrite,
    input  wire logic [dispPkg::DATA_W-1:0]  pwdata,
    output logic      [dispPkg::DATA_W-1:0]  prdata,
    output logic                             pready,
    output logic                             pslverr,
    dispCfgIf.regs                           cfg
);

    dispPkg::regAddrE             addr;
    logic                         addrOk;       // address is in the map
    logic                         setupCyc;
    logic                         accessCyc;
    logic                         wrEn;
    logic [dispPkg::DATA_W-1:0]   rdData;

    logic [dispPkg::VALUE_W-1:0]  valueReg;
    logic                         enableReg;
    logic                         negReg;
    logic [CNT_W-1:0]             intervalReg;

    assign addr      = dispPkg::regAddrE'(paddr);
    assign setupCyc  = psel && !penable;
    assign accessCyc = psel && penable;
    assign wrEn      = accessCyc && pwrite && addrOk;

    assign pready = 1'b1;   // never stalls

    // address decode and read mux
    always_comb begin
        addrOk = 1'b1;
        rdData = '0;
        case (addr)
            dispPkg::VALUE_ADDR:    rdData[dispPkg::VALUE_W-1:0] = valueReg;
            dispPkg::CTRL_ADDR:     rdData[1:0] = {negReg, enableReg};
            dispPkg::INTERVAL_ADDR: rdData[CNT_W-1:0] = intervalReg;
            dispPkg::STATUS_ADDR:   rdData[1:0] = cfg.sel;  // live digit select
            default: begin
                addrOk = 1'b0;
                rdData = '0;
            end
        endcase
    end

    // register writes land at the end of the access cycle
    always_ff @(posedge CLK) begin
        if (!rstN) begin
            valueReg    <= '0;
            enableReg   <= 1'b0;
            negReg      <= 1'b0;
            intervalReg <= CNT_W'(RESET_INTERVAL);
        end else if (wrEn) begin
            case (addr)
                dispPkg::VALUE_ADDR: begin
                    valueReg <= pwdata[dispPkg::VALUE_W-1:0];
                end
                dispPkg::CTRL_ADDR: begin
                    enableReg <= pwdata[0];
                    negReg    <= pwdata[1];
                end
                dispPkg::INTERVAL_ADDR: begin
                    intervalReg <= pwdata[CNT_W-1:0];
                end
                default: ;  // status is read only
            endcase
        end
    end

    // read data and error captured in setup, held through access
    always_ff @(posedge CLK) begin
        if (!rstN) begin
            prdata  <= '0;
            pslverr <= 1'b0;
        end else begin
            pslverr <= setupCyc && !addrOk;
            if (setupCyc && !pwrite) begin
                prdata <= rdData;
            end else begin
                prdata <= '0;
            end
        end
    end

    // fields out to the scan engine
    assign cfg.value    = valueReg;
    assign cfg.neg      = negReg;
    assign cfg.enable   = enableReg;
    assign cfg.interval = intervalReg;

    // slave error only ever shows up in the access phase
    property pErrInAccess;
        @(posedge CLK) disable iff (!rstN)
            pslverr |-> (psel && penable && $past(psel && !penable));
    endproperty

    aErrInAccess: assert property (pErrInAccess)
        else $error("pslverr raised outside an APB access cycle");

endmodule

`default_nettype wire

//--- design/dispScan.sv
// ***********************************************************
// dispScan: interval counter and digit rotation, drives the
// registered anode, segment and decimal point pattern
// ***********************************************************
`default_nettype none

module dispScan #(
    parameter int CNT_W = 16
) (
    input  wire logic                       CLK,
    input  wire logic                       rstN,
    dispCfgIf.scan                          cfg,
    output logic [dispPkg::DIGITS+7:0]      disp
);

    localparam int DISP_W = dispPkg::DIGITS + 8;

    logic [CNT_W-1:0]           cnt;
    logic                       tick;
    dispPkg::digitSelE          selQ;
    dispPkg::digitSelE          selNext;
    logic [3:0]                 nibble;
    logic [dispPkg::DIGITS-1:0] anodeN;     // active low
    logic [6:0]                 segN;       // active low, a to g
    logic                       dpN;        // active low decimal point
    logic [DISP_W-1:0]          dispNext;

    // tick when the count reaches the interval
    assign tick = (cnt == cfg.interval);

    // a count above a freshly lowered interval runs on and wraps at max
    always_ff @(posedge CLK) begin
        if (!rstN) begin
            cnt <= '0;
        end else if (tick) begin
            cnt <= '0;
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

    // next digit in rotation
    always_comb begin
        case (selQ)
            dispPkg::DIG0: selNext = dispPkg::DIG1;
            dispPkg::DIG1: selNext = dispPkg::DIG2;
            dispPkg::DIG2: selNext = dispPkg::DIG3;
            dispPkg::DIG3: selNext = dispPkg::DIG0;
            default:       selNext = dispPkg::DIG0;
        endcase
    end

    always_ff @(posedge CLK) begin
        if (!rstN) begin
            selQ <= dispPkg::DIG0;
        end else if (tick) begin
            selQ <= selNext;
        end
    end

    assign cfg.sel = selQ;  // back to status register

    // pick the nibble for the current digit
    assign nibble = cfg.value[{selQ, 2'b00} +: 4];

    // one anode pulled low for the current digit
    always_comb begin
        anodeN       = '1;
        anodeN[selQ] = 1'b0;
    end

    assign segN = dispPkg::hexToSeg(nibble);
    assign dpN  = !((selQ == dispPkg::DIG0) && cfg.neg);   // minus sign on DIG0

    // blank pattern while disabled
    assign dispNext = cfg.enable ? {anodeN, segN, dpN} : '1;

    // output only changes on a tick
    always_ff @(posedge CLK) begin
        if (!rstN) begin
            disp <= '1;
        end else if (tick) begin
            disp <= dispNext;
        end
    end

    // at most one digit driven at a time
    property pOneAnode;
        @(posedge CLK) disable iff (!rstN)
            $onehot0(~disp[DISP_W-1:8]);
    endproperty

    aOneAnode: assert property (pOneAnode)
        else $error("more than one anode active on disp");

    // decimal point only ever lights with the DIG0 anode
    property pDpOnDig0;
        @(posedge CLK) disable iff (!rstN)
            !disp[0] |-> (disp[DISP_W-1:8] == {{(dispPkg::DIGITS-1){1'b1}}, 1'b0});
    endproperty

    aDpOnDig0: assert property (pDpOnDig0)
        else $error("decimal point lit away from DIG0");

endmodule

`default_nettype wire

//--- design/segDisplay.sv
// ***********************************************************
// segDisplay: four-digit seven-segment controller top level,
// APB register block feeding the scan engine
// ***********************************************************
`default_nettype none

module segDisplay #(
    parameter int CNT_W          = 16,      // interval counter width
    parameter int RESET_INTERVAL = 49999    // 1 ms at 50 MHz per digit
) (
    input  wire logic                        CLK,
    input  wire logic                        rstN,

    // APB slave
    input  wire logic [dispPkg::ADDR_W-1:0]  paddr,
    input  wire logic                        psel,
    input  wire logic                        penable,
    input  wire logic                        pwrite,
    input  wire logic [dispPkg::DATA_W-1:0]  pwdata,
    output logic      [dispPkg::DATA_W-1:0]  prdata,
    output logic                             pready,
    output logic                             pslverr,

    // anodes, segments a to g, decimal point, all active low
    output logic      [dispPkg::DIGITS+7:0]  disp
);

    // register fields to the scan engine
    dispCfgIf #(
        .CNT_W (CNT_W)
    ) cfgBus ();

    dispRegs #(
        .CNT_W          (CNT_W),
        .RESET_INTERVAL (RESET_INTERVAL)
    ) uRegs (
        .CLK     (CLK),
        .rstN    (rstN),
        .paddr   (paddr),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .cfg     (cfgBus.regs)
    );

    dispScan #(
        .CNT_W (CNT_W)
    ) uScan (
        .CLK  (CLK),
        .rstN (rstN),
        .cfg  (cfgBus.scan),
        .disp (disp)
    );

endmodule

`default_nettype wire

//--- sim/tbSegDisplay.sv
// ***********************************************************
// tbSegDisplay: APB stimulus for the seven-segment controller,
// shadow register and scan model checked by assertions
// ***********************************************************
`default_nettype none

module tbSegDisplay;

    localparam int CNT_W        = 16;
    localparam int RST_INTERVAL = 5;    // short scan for simulation
    localparam int MAX_INTERVAL = 7;    // largest interval the tests use
    localparam int TICK_BUDGET  = 120;  // ticks waited on over all tests
    localparam int CYCLE_LIMIT  = TICK_BUDGET * (MAX_INTERVAL + 1) + 1000;

    logic        CLK;
    logic        rstN;
    logic [3:0]  paddr;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
    logic [11:0] disp;

    // shadow registers and scan model
    logic [15:0]      shadowValue;
    logic             shadowEn;
    logic             shadowNeg;
    logic [CNT_W-1:0] shadowInterval;
    logic [CNT_W-1:0] modelCnt;
    logic [1:0]       modelSel;
    logic [11:0]      modelDisp;
    logic             modelTick;
    logic [31:0]      expRead;
    logic             addrMapped;

    int errCount;
    int cycleCount;
    int seed;

    segDisplay #(
        .CNT_W          (CNT_W),
        .RESET_INTERVAL (RST_INTERVAL)
    ) DUT (
        .CLK     (CLK),
        .rstN    (rstN),
        .paddr   (paddr),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .disp    (disp)
    );

    initial begin
        CLK = 1'b0;
        forever #5 CLK = ~CLK;
    end

    // active-low glyphs, built from the lit segments a to g
    function automatic logic [6:0] segmentsFor(input logic [3:0] nib);
        logic [6:0] lit;
        case (nib)
            4'h0:    lit = 7'b1111110;
            4'h1:    lit = 7'b0110000;
            4'h2:    lit = 7'b1101101;
            4'h3:    lit = 7'b1111001;
            4'h4:    lit = 7'b0110011;
            4'h5:    lit = 7'b1011011;
            4'h6:    lit = 7'b1011111;
            4'h7:    lit = 7'b1110000;
            4'h8:    lit = 7'b1111111;
            4'h9:    lit = 7'b1111011;
            4'hA:    lit = 7'b1110111;
            4'hB:    lit = 7'b0011111;  // b
            4'hC:    lit = 7'b1001110;
            4'hD:    lit = 7'b0111101;  // d
            4'hE:    lit = 7'b1001111;
            default: lit = 7'b1000111;  // F
        endcase
        return ~lit;
    endfunction

    // expected display word for one digit
    function automatic logic [11:0] framePattern(input logic [1:0] dig,
                                                 input logic [15:0] val,
                                                 input logic neg);
        logic [3:0] anodes;
        logic [3:0] nib;
        logic       dp;
        anodes      = 4'b1111;
        anodes[dig] = 1'b0;
        nib         = val[dig*4 +: 4];
        dp          = !(dig == 2'd0 && neg);
        return {anodes, segmentsFor(nib), dp};
    endfunction

    assign modelTick = (modelCnt == shadowInterval);

    always_comb begin
        addrMapped = 1'b1;
        case (paddr)
            dispPkg::VALUE_ADDR:    expRead = {16'h0, shadowValue};
            dispPkg::CTRL_ADDR:     expRead = {30'h0, shadowNeg, shadowEn};
            dispPkg::INTERVAL_ADDR: expRead = {16'h0, shadowInterval};
            dispPkg::STATUS_ADDR:   expRead = {30'h0, modelSel};
            default: begin
                addrMapped = 1'b0;
                expRead    = '0;
            end
        endcase
    end

    always @(posedge CLK) begin
        if (!rstN) begin
            shadowValue    <= '0;
            shadowEn       <= 1'b0;
            shadowNeg      <= 1'b0;
            shadowInterval <= CNT_W'(RST_INTERVAL);
            modelCnt       <= '0;
            modelSel       <= 2'd0;
            modelDisp      <= '1;
        end else begin
            if (psel && penable && pwrite) begin    // write lands at end of access
                case (paddr)
                    dispPkg::VALUE_ADDR:    shadowValue <= pwdata[15:0];
                    dispPkg::CTRL_ADDR: begin
                        shadowEn  <= pwdata[0];
                        shadowNeg <= pwdata[1];
                    end
                    dispPkg::INTERVAL_ADDR: shadowInterval <= pwdata[CNT_W-1:0];
                    default: ;
                endcase
            end
            if (modelTick) begin
                modelCnt  <= '0;
                modelSel  <= modelSel + 2'd1;
                modelDisp <= shadowEn ? framePattern(modelSel, shadowValue, shadowNeg) : '1;
            end else begin
                modelCnt <= modelCnt + 16'd1;
            end
        end
    end

    aDispModel: assert property (@(posedge CLK) disable iff (!rstN) disp == modelDisp)
        else begin
            errCount++;
            $display("Error at %0t: disp %h, expected %h", $time,
                     $sampled(disp), $sampled(modelDisp));
        end

    // read data was captured from the setup cycle
    aReadData: assert property (@(posedge CLK) disable iff (!rstN)
        (psel && penable && !pwrite) |-> prdata == $past(expRead))
        else begin
            errCount++;
            $display("Error at %0t: read of %h gave %h, expected %h", $time,
                     $sampled(paddr), $sampled(prdata), $past(expRead));
        end

    aSlvErr: assert property (@(posedge CLK) disable iff (!rstN)
        pslverr == (psel && penable && !addrMapped))
        else begin
            errCount++;
            $display("Error at %0t: pslverr %b at address %h", $time,
                     $sampled(pslverr), $sampled(paddr));
        end

    aReady: assert property (@(posedge CLK) disable iff (!rstN) pready)
        else begin
            errCount++;
            $display("Error at %0t: pready went low", $time);
        end

    task automatic resetDut();
        @(posedge CLK);
        rstN <= 1'b0;
        repeat (16) @(posedge CLK);
        rstN <= 1'b1;
    endtask

    task automatic apbXfer(input logic [3:0] a, input logic wr, input logic [31:0] d);
        @(posedge CLK);             // setup
        paddr   <= a;
        pwrite  <= wr;
        pwdata  <= d;
        psel    <= 1'b1;
        penable <= 1'b0;
        @(posedge CLK);             // access
        penable <= 1'b1;
        @(posedge CLK);
        psel    <= 1'b0;
        penable <= 1'b0;
        pwrite  <= 1'b0;
    endtask

    task automatic readAll();
        apbXfer(dispPkg::VALUE_ADDR, 1'b0, 32'h0);
        apbXfer(dispPkg::CTRL_ADDR, 1'b0, 32'h0);
        apbXfer(dispPkg::INTERVAL_ADDR, 1'b0, 32'h0);
        apbXfer(dispPkg::STATUS_ADDR, 1'b0, 32'h0);
    endtask

    task automatic waitTicks(input int n);
        int seen;
        seen = 0;
        while (seen < n) begin
            @(posedge CLK);
            if (modelTick) seen++;
        end
    endtask

    // write just after a tick so the counter is below the new interval
    task automatic setInterval(input int v);
        waitTicks(1);
        apbXfer(dispPkg::INTERVAL_ADDR, 1'b1, 32'(v));
    endtask

    initial begin
        cycleCount = 0;
        while (cycleCount < CYCLE_LIMIT) begin
            @(posedge CLK);
            cycleCount++;
        end
        $display("Test timed out after %0d cycles, %0d errors so far", cycleCount, errCount);
        $display("TEST FAIL");
        $finish;
    end

    initial begin
        logic [3:0] badAddr;
        errCount = 0;
        seed     = 32'ha4b9;
        rstN     = 1'b0;
        paddr    = '0;
        psel     = 1'b0;
        penable  = 1'b0;
        pwrite   = 1'b0;
        pwdata   = '0;

        resetDut();
        readAll();                  // reset values
        repeat (8) begin
            apbXfer(dispPkg::CTRL_ADDR, 1'b1, 32'h0);   // disabled before the interval moves
            apbXfer(dispPkg::VALUE_ADDR, 1'b1, $random(seed));
            apbXfer(dispPkg::INTERVAL_ADDR, 1'b1, $random(seed));
            apbXfer(dispPkg::CTRL_ADDR, 1'b1, $random(seed));
            readAll();
        end
        repeat (6) begin            // unmapped offsets
            badAddr = 4'($random(seed));
            if (badAddr[1:0] == 2'b00) badAddr[0] = 1'b1;
            apbXfer(badAddr, 1'b1, $random(seed));
            apbXfer(badAddr, 1'b0, 32'h0);
            readAll();
        end

        resetDut();                 // back to the short reset interval
        apbXfer(dispPkg::CTRL_ADDR, 1'b1, 32'h1);
        repeat (6) begin
            apbXfer(dispPkg::VALUE_ADDR, 1'b1, $random(seed));
            waitTicks(8);
        end
        apbXfer(dispPkg::CTRL_ADDR, 1'b1, 32'h3);   // neg on
        waitTicks(8);
        apbXfer(dispPkg::CTRL_ADDR, 1'b1, 32'h1);
        waitTicks(8);

        apbXfer(dispPkg::CTRL_ADDR, 1'b1, 32'h0);
        setInterval(3);
        apbXfer(dispPkg::CTRL_ADDR, 1'b1, 32'h1);
        waitTicks(12);
        apbXfer(dispPkg::CTRL_ADDR, 1'b1, 32'h0);
        setInterval(7);
        apbXfer(dispPkg::CTRL_ADDR, 1'b1, 32'h3);
        waitTicks(12);

        apbXfer(dispPkg::CTRL_ADDR, 1'b1, 32'h2);   // blank, neg kept
        waitTicks(4);
        apbXfer(dispPkg::CTRL_ADDR, 1'b1, 32'h3);
        waitTicks(4);
        readAll();

        $display("Checks finished with %0d errors", errCount);
        if (errCount == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- segDisplay.f
design/dispPkg.sv
design/dispCfgIf.sv
design/dispRegs.sv
design/dispScan.sv
design/segDisplay.sv
sim/tbSegDisplay.sv

//--- run.sh
#!/bin/sh
# Build the seven-segment controller testbench with Verilator and run it.
set -e

cd "$(dirname "$0")"

LOG=sim.log

rm -rf obj_dir
verilator --binary --assert \
    --top-module tbSegDisplay \
    -f segDisplay.f \
    -o simv

# tee keeps the pipeline status, the log search decides pass or fail
./obj_dir/simv | tee "$LOG"

if grep -q "^TEST PASS$" "$LOG"; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed, see $LOG"
    exit 1
fi
